//--- filelist.f
+incdir+logic
logic/rxPathPkg.sv
logic/uartReceiver.sv
logic/rxFifo.sv
logic/wordAssembler.sv
logic/rxPathTop.sv
tests/rxPathChecker.sv
tests/rxPathTb.sv

//--- Bender.yml
package:
  name: rx_path

export_include_dirs:
  - logic

sources:
  - logic/rxPathPkg.sv
  - logic/uartReceiver.sv
  - logic/rxFifo.sv
  - logic/wordAssembler.sv
  - logic/rxPathTop.sv
  - target: test
    files:
      - tests/rxPathChecker.sv
      - tests/rxPathTb.sv

//--- tests/rxPathTb.sv
`timescale 1ns/1ps
`include "rxPath_params.svh"

module rxPathTb;

        import rxPathPkg::*;

        localparam int NUM_FRAMES     = 47;                        // All frames sent below
        localparam int TIMEOUT_CYCLES = 3 * NUM_FRAMES * 160;

        typedef struct packed {
                logic                  isCmd;
                logic [`WORD_BITS-1:0] word;
        } expT;

        logic                  Data_Rdy;
        logic                  Pop_Data;
        logic                  serialIn;
        logic                  bistMode;
        logic                  drainEn;
        logic                  frameErr;
        logic                  fifoEmpty;
        logic                  fifoHalfFull;
        logic                  fifoFull;
        logic                  dataValid;
        logic [`WORD_BITS-1:0] dataWord;
        logic                  cmdValid;
        cmdFieldsT             cmdWord;
        int                    seed = 21;
        int                    cycleCount;

        always #5 Data_Rdy = ~Data_Rdy;                            // 10 ns period

        rxPathTop i_dut (.*);

        rxPathChecker i_checker (.*);

        // Kind and value expected from a high and a low byte
        function automatic expT refWord(input logic [7:0] hi, input logic [7:0] lo);
                expT e;
                e.isCmd = (hi[7:4] != OPC_DATA);                  // Opcode is the top nibble
                e.word  = {hi[7:4], hi[3:0], lo};                  // Opcode, channel, payload
                return e;
        endfunction

        ////////////////////
        // Serial stimulus
        ////////////////////

        task automatic sendFrame(input logic [7:0] value, input logic stopBit);
                logic [9:0] bits;
                bits = {stopBit, value, 1'b0};                     // Start bit goes first
                for (int i = 0; i < 10; i++) begin
                        serialIn <= bits[i];
                        repeat (`CLKS_PER_BIT) @(posedge Data_Rdy);
                end
                serialIn <= 1'b1;                                  // One idle bit between frames
                repeat (`CLKS_PER_BIT) @(posedge Data_Rdy);
        endtask

        task automatic sendPair(input logic [7:0] hi, input logic [7:0] lo);
                expT e;
                e = refWord(hi, lo);
                i_checker.expectWord(e.isCmd, e.word);
                sendFrame(hi, 1'b1);
                sendFrame(lo, 1'b1);
        endtask

        task automatic waitDrained();
                while (i_checker.pendingWords() != 0 || !fifoEmpty) begin
                        @(posedge Data_Rdy);
                end
                repeat (4) @(posedge Data_Rdy);                    // Room for a stray word
        endtask

        initial begin : stimulus
                int         r;
                logic [3:0] op;
                logic [7:0] burst [18];
                expT        e;
                Data_Rdy = 1'b0;
                Pop_Data = 1'b1;
                serialIn = 1'b1;                                   // Line idles high
                bistMode = 1'b0;
                drainEn  = 1'b0;
                repeat (8) @(posedge Data_Rdy);
                Pop_Data <= 1'b0;
                @(posedge Data_Rdy);
                i_checker.checkFlags(1'b1, 1'b0, 1'b0);            // Reset state
                i_checker.checkQuiet();

                //////////////////// Data words then commands
                drainEn <= 1'b1;
                for (int i = 0; i < 4; i++) begin
                        r = $random(seed);
                        sendPair({4'h0, r[3:0]}, r[15:8]);
                end
                for (int i = 0; i < 4; i++) begin
                        r  = $random(seed);
                        op = (r[7:4] == 4'h0) ? 4'h9 : r[7:4];    // Nonzero opcode
                        sendPair({op, r[3:0]}, r[15:8]);
                end
                waitDrained();

                //////////////////// Fill past full so the last two bytes drop
                drainEn <= 1'b0;
                for (int i = 0; i < 18; i++) begin
                        r        = $random(seed);
                        burst[i] = r[7:0];
                end
                for (int i = 0; i < 16; i += 2) begin
                        e = refWord(burst[i], burst[i+1]);
                        i_checker.expectWord(e.isCmd, e.word);
                end
                for (int i = 0; i < 18; i++) begin
                        sendFrame(burst[i], 1'b1);
                        i_checker.checkFlags(1'b0, i >= 7, i >= 15);
                end
                drainEn <= 1'b1;
                waitDrained();
                i_checker.checkFlags(1'b1, 1'b0, 1'b0);

                //////////////////// Bad stop bit
                drainEn <= 1'b0;
                sendFrame(8'hA5, 1'b0);
                i_checker.checkFlags(1'b1, 1'b0, 1'b0);            // Nothing stored
                i_checker.checkErrPulses(1);
                drainEn <= 1'b1;
                sendPair(8'h12, 8'h34);
                sendPair(8'h3C, 8'h5A);
                waitDrained();

                //////////////////// BIST freeze with six bytes held
                drainEn <= 1'b0;
                for (int i = 0; i < 3; i++) begin
                        r = $random(seed);
                        sendPair(r[15:8], r[7:0]);
                end
                i_checker.checkFlags(1'b0, 1'b0, 1'b0);
                bistMode <= 1'b1;
                @(posedge Data_Rdy);
                sendFrame(8'h77, 1'b1);                            // Would reach half full
                sendFrame(8'h88, 1'b1);
                i_checker.checkFlags(1'b0, 1'b0, 1'b0);
                bistMode <= 1'b0;
                @(posedge Data_Rdy);
                drainEn <= 1'b1;
                waitDrained();

                i_checker.checkErrPulses(1);
                i_checker.checkAllSeen();
                $display("Checked %0d words, %0d errors", i_checker.wordCount,
                         i_checker.errCount);
                if (i_checker.errCount == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

        initial begin : watchdog
                cycleCount = 0;
                while (cycleCount < TIMEOUT_CYCLES) begin
                        @(posedge Data_Rdy);
                        cycleCount++;
                end
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("TEST FAILED");
                $finish;
        end

endmodule

//--- tests/rxPathChecker.sv
`timescale 1ns/1ps
`include "rxPath_params.svh"

module rxPathChecker (
        input  logic                  Data_Rdy,
        input  logic                  Pop_Data,
        input  logic                  bistMode,
        input  logic                  frameErr,
        input  logic                  fifoEmpty,
        input  logic                  fifoHalfFull,
        input  logic                  fifoFull,
        input  logic                  dataValid,
        input  logic [`WORD_BITS-1:0] dataWord,
        input  logic                  cmdValid,
        input  rxPathPkg::cmdFieldsT  cmdWord
);

        // Expected word together with its kind
        typedef struct packed {
                logic                  isCmd;   // Command, else data
                logic [`WORD_BITS-1:0] word;    // Raw view of the pair
        } entryT;

        entryT expQ [$];           // Oldest word first
        int    errCount  = 0;
        int    wordCount = 0;      // Words compared
        int    errPulses = 0;      // frameErr pulses seen

        task automatic reportMismatch(input string name, input logic [15:0] got,
                                      input logic [15:0] want);
                $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, want);
                errCount++;
        endtask

        // Called by the testbench in send order
        task automatic expectWord(input logic isCmd, input logic [`WORD_BITS-1:0] word);
                expQ.push_back('{isCmd: isCmd, word: word});
        endtask

        function automatic int pendingWords();
                return expQ.size();
        endfunction

        ////////////////////
        // Word compare
        ////////////////////

        task automatic compareWord();
                entryT want;
                if (expQ.size() == 0) begin
                        $display("Error at %0t: a word came out that no sent pair explains", $time);
                        errCount++;
                end else begin
                        want = expQ.pop_front();
                        wordCount++;
                        if (cmdValid !== want.isCmd) begin
                                reportMismatch("cmdValid", cmdValid, want.isCmd);  // Wrong kind
                        end else if (want.isCmd && cmdWord !== want.word) begin
                                reportMismatch("cmdWord", cmdWord, want.word);
                        end else if (!want.isCmd && dataWord !== want.word) begin
                                reportMismatch("dataWord", dataWord, want.word);
                        end
                end
        endtask

        // Ports watched on every rising edge
        always @(posedge Data_Rdy) begin
                if (!Pop_Data) begin
                        if (frameErr) begin
                                errPulses++;
                        end
                        if (dataValid && cmdValid) begin
                                $display("Error at %0t: dataValid and cmdValid pulsed together",
                                         $time);
                                errCount++;
                        end
                        if ((dataValid || cmdValid) && bistMode) begin
                                $display("Error at %0t: a word came out during BIST mode", $time);
                                errCount++;
                        end
                        if (dataValid || cmdValid) begin
                                compareWord();
                        end
                end
        end

        ////////////////////
        // Level checks
        ////////////////////

        task automatic checkFlags(input logic wantEmpty, input logic wantHalf,
                                  input logic wantFull);
                if (fifoEmpty !== wantEmpty) begin
                        reportMismatch("fifoEmpty", fifoEmpty, wantEmpty);
                end
                if (fifoHalfFull !== wantHalf) begin
                        reportMismatch("fifoHalfFull", fifoHalfFull, wantHalf);
                end
                if (fifoFull !== wantFull) begin
                        reportMismatch("fifoFull", fifoFull, wantFull);
                end
        endtask

        task automatic checkQuiet();
                if (frameErr !== 1'b0) begin
                        reportMismatch("frameErr", frameErr, 1'b0);
                end
                if (dataValid !== 1'b0) begin
                        reportMismatch("dataValid", dataValid, 1'b0);
                end
                if (cmdValid !== 1'b0) begin
                        reportMismatch("cmdValid", cmdValid, 1'b0);
                end
        endtask

        task automatic checkErrPulses(input int wantCount);
                if (errPulses != wantCount) begin
                        reportMismatch("frameErr pulse count", errPulses, wantCount);
                end
        endtask

        task automatic checkAllSeen();
                if (expQ.size() != 0) begin
                        $display("Error: %0d expected words never came out", expQ.size());
                        errCount++;
                end
        endtask

endmodule

//--- logic/rxPathTop.sv
`timescale 1ns/1ps
`include "rxPath_params.svh"

module rxPathTop (
        input  logic                  Data_Rdy,       // System clock
        input  logic                  Pop_Data,       // Async reset, active high
        input  logic                  serialIn,       // Serial line in
        input  logic                  bistMode,       // Freezes the FIFO
        input  logic                  drainEn,        // Lets the assembler pop
        output logic                  frameErr,       // Pulse on a bad stop bit
        output logic                  fifoEmpty,
        output logic                  fifoHalfFull,
        output logic                  fifoFull,
        output logic                  dataValid,
        output logic [`WORD_BITS-1:0] dataWord,
        output logic                  cmdValid,
        output rxPathPkg::cmdFieldsT  cmdWord
);

        import rxPathPkg::*;

        rxByteT                rxByte;        // Receiver to FIFO
        logic                  rxStrobe;
        logic                  popReq;        // Assembler to FIFO
        logic [`DATA_BITS-1:0] dataOut;       // FIFO to assembler

        assign frameErr = rxByte.frameErr;    // Already a one-cycle pulse

        ////////////////////
        // Producer
        ////////////////////

        uartReceiver i_receiver (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .serialIn (serialIn),
                .rxByte   (rxByte),
                .rxStrobe (rxStrobe)
        );

        ////////////////////
        // Buffer
        ////////////////////

        rxFifo #(
                .addrBits (`FIFO_ADDR_BITS)
        ) i_fifo (
                .Data_Rdy     (Data_Rdy),
                .Pop_Data     (Pop_Data),
                .rxByte       (rxByte),
                .rxStrobe     (rxStrobe),
                .popReq       (popReq),
                .bistMode     (bistMode),
                .fifoEmpty    (fifoEmpty),
                .fifoHalfFull (fifoHalfFull),
                .fifoFull     (fifoFull),
                .dataOut      (dataOut)
        );

        ////////////////////
        // Consumer
        ////////////////////

        wordAssembler i_assembler (
                .Data_Rdy  (Data_Rdy),
                .Pop_Data  (Pop_Data),
                .fifoEmpty (fifoEmpty),
                .drainEn   (drainEn),
                .dataOut   (dataOut),
                .popReq    (popReq),
                .dataValid (dataValid),
                .cmdValid  (cmdValid),
                .dataWord  (dataWord),
                .cmdWord   (cmdWord)
        );

endmodule

//--- logic/wordAssembler.sv
`timescale 1ns/1ps
`include "rxPath_params.svh"

module wordAssembler (
        input  logic                  Data_Rdy,      // System clock
        input  logic                  Pop_Data,      // Async reset, active high
        input  logic                  fifoEmpty,
        input  logic                  drainEn,       // Allows popping
        input  logic [`DATA_BITS-1:0] dataOut,       // Byte from the FIFO
        output logic                  popReq,
        output logic                  dataValid,     // Raw data word ready
        output logic                  cmdValid,      // Command word ready
        output logic [`WORD_BITS-1:0] dataWord,
        output rxPathPkg::cmdFieldsT  cmdWord
);

        import rxPathPkg::*;

        rxWordU wordReg;        // Assembled word, both views
        logic   popPending;     // Popped byte shows on dataOut now
        logic   lowPhase;       // Next byte is the low byte

        ////////////////////
        // Pop control
        ////////////////////

        // One pop in flight at most
        assign popReq = ~fifoEmpty & drainEn & ~popPending;

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        popPending <= 1'b0;
                        lowPhase   <= 1'b0;                  // Expect high byte
                        dataValid  <= 1'b0;
                        cmdValid   <= 1'b0;
                end else begin
                        popPending <= popReq;                // Byte lands next cycle
                        dataValid  <= 1'b0;
                        cmdValid   <= 1'b0;
                        if (popPending) begin
                                lowPhase <= ~lowPhase;
                                if (lowPhase) begin
                                        // Opcode sits in the high byte, already stored
                                        dataValid <= (wordReg.cmd.opcode == OPC_DATA);
                                        cmdValid  <= (wordReg.cmd.opcode != OPC_DATA);
                                end
                        end
                end
        end

        ////////////////////
        // Word register
        ////////////////////

        always_ff @(posedge Data_Rdy) begin
                if (popPending) begin
                        if (lowPhase) begin
                                wordReg.raw[`DATA_BITS-1:0] <= dataOut;            // Second byte
                        end else begin
                                wordReg.raw[`WORD_BITS-1:`DATA_BITS] <= dataOut;   // First byte
                        end
                end
        end

        // Each output reads the view that fits it
        assign dataWord = wordReg.raw;
        assign cmdWord  = wordReg.cmd;

endmodule

//--- logic/rxFifo.sv
`timescale 1ns/1ps
`include "rxPath_params.svh"

module rxFifo #(
        parameter int addrBits = `FIFO_ADDR_BITS      // log2 of entry count
) (
        input  logic                  Data_Rdy,       // System clock
        input  logic                  Pop_Data,       // Async reset, active high
        input  rxPathPkg::rxByteT     rxByte,         // Byte from the receiver
        input  logic                  rxStrobe,       // Write request
        input  logic                  popReq,         // Read request
        input  logic                  bistMode,       // Freezes the whole FIFO
        output logic                  fifoEmpty,
        output logic                  fifoHalfFull,
        output logic                  fifoFull,
        output logic [`DATA_BITS-1:0] dataOut         // Registered read data
);

        localparam int DEPTH    = 2 ** addrBits;
        localparam int CNT_BITS = addrBits + 1;       // Must hold DEPTH itself
        localparam logic [CNT_BITS-1:0] HALF_MARK = CNT_BITS'(DEPTH / 2);
        localparam logic [CNT_BITS-1:0] FULL_MARK = CNT_BITS'(DEPTH);

        logic [`DATA_BITS-1:0] mem [DEPTH];           // Circular storage
        logic [addrBits-1:0]   wrPtr;
        logic [addrBits-1:0]   rdPtr;
        logic [CNT_BITS-1:0]   count;                 // Entries stored
        logic [CNT_BITS-1:0]   countNext;
        logic                  wrEn;
        logic                  rdEn;

        ////////////////////
        // Request qualify
        ////////////////////

        // Bad frames, full FIFO or BIST drop the byte
        assign wrEn = rxStrobe & ~rxByte.frameErr & ~fifoFull & ~bistMode;
        // Pops on empty are ignored
        assign rdEn = popReq & ~fifoEmpty & ~bistMode;

        always_comb begin
                case ({wrEn, rdEn})
                        2'b10:   countNext = count + 1'b1;   // Write only
                        2'b01:   countNext = count - 1'b1;   // Read only
                        default: countNext = count;          // Both cancel, or idle
                endcase
        end

        ////////////////////
        // Pointers, flags
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        wrPtr        <= '0;
                        rdPtr        <= '0;
                        count        <= '0;
                        fifoEmpty    <= 1'b1;
                        fifoHalfFull <= 1'b0;
                        fifoFull     <= 1'b0;
                end else begin
                        if (wrEn) begin
                                wrPtr <= wrPtr + 1'b1;       // Wraps around
                        end
                        if (rdEn) begin
                                rdPtr <= rdPtr + 1'b1;
                        end
                        count <= countNext;
                        // Flags follow the new count, so they hold under BIST
                        fifoEmpty    <= (countNext == '0);
                        fifoHalfFull <= (countNext >= HALF_MARK);
                        fifoFull     <= (countNext == FULL_MARK);
                end
        end

        ////////////////////
        // Storage, read out
        ////////////////////

        always_ff @(posedge Data_Rdy) begin
                if (wrEn) begin
                        mem[wrPtr] <= rxByte.data;
                end
                if (rdEn) begin
                        dataOut <= mem[rdPtr];               // Lands the cycle after popReq
                end
        end

endmodule

//--- logic/uartReceiver.sv
`timescale 1ns/1ps
`include "rxPath_params.svh"

module uartReceiver (
        input  logic              Data_Rdy,    // System clock
        input  logic              Pop_Data,    // Async reset, active high
        input  logic              serialIn,    // Raw serial line, idles high
        output rxPathPkg::rxByteT rxByte,      // Received byte with framing flag
        output logic              rxStrobe     // One-cycle pulse per frame
);

        localparam int CNT_BITS = $clog2(`CLKS_PER_BIT);
        localparam int IDX_BITS = $clog2(`DATA_BITS);
        localparam logic [CNT_BITS-1:0] HALF_BIT = CNT_BITS'(`CLKS_PER_BIT / 2 - 1);
        localparam logic [CNT_BITS-1:0] FULL_BIT = CNT_BITS'(`CLKS_PER_BIT - 1);
        localparam logic [IDX_BITS-1:0] LAST_BIT = IDX_BITS'(`DATA_BITS - 1);

        typedef enum logic [1:0] {
                stIdle,        // Waiting for a falling edge
                stStart,       // Checking start bit at half a bit
                stData,        // Shifting data bits
                stStop         // Sampling stop bit
        } rxStateT;

        rxStateT               state;
        logic [CNT_BITS-1:0]   tickCnt;     // Clocks within current bit
        logic [IDX_BITS-1:0]   bitIdx;      // Data bit being received
        logic [`DATA_BITS-1:0] shiftReg;    // Bits enter at the top
        logic                  errPulse;    // Framing error, same cycle as strobe
        logic                  serialMeta;
        logic                  serialSync;
        logic                  serialPrev;
        logic                  startEdge;
        logic                  bitMiddle;

        ////////////////////
        // Line synchronizer
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        serialMeta <= 1'b1;             // Line idles high
                        serialSync <= 1'b1;
                        serialPrev <= 1'b1;
                end else begin
                        serialMeta <= serialIn;         // First stage
                        serialSync <= serialMeta;       // Second stage
                        serialPrev <= serialSync;       // For edge detection
                end
        end

        assign startEdge = serialPrev & ~serialSync;   // High to low
        assign bitMiddle = (tickCnt == FULL_BIT);      // One full bit since last sample

        ////////////////////
        // Frame FSM
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        state    <= stIdle;
                        tickCnt  <= '0;
                        bitIdx   <= '0;
                        rxStrobe <= 1'b0;
                        errPulse <= 1'b0;
                end else begin
                        rxStrobe <= 1'b0;               // Pulses by default
                        errPulse <= 1'b0;
                        case (state)
                                stIdle: begin
                                        tickCnt <= '0;
                                        if (startEdge) begin
                                                state <= stStart;
                                        end
                                end
                                stStart: begin
                                        if (tickCnt == HALF_BIT) begin
                                                tickCnt <= '0;
                                                bitIdx  <= '0;
                                                // Line back high means a glitch
                                                state   <= serialSync ? stIdle : stData;
                                        end else begin
                                                tickCnt <= tickCnt + 1'b1;
                                        end
                                end
                                stData: begin
                                        tickCnt <= tickCnt + 1'b1;   // Wraps at bit end
                                        if (bitMiddle) begin
                                                bitIdx <= bitIdx + 1'b1;
                                                if (bitIdx == LAST_BIT) begin
                                                        state <= stStop;
                                                end
                                        end
                                end
                                stStop: begin
                                        tickCnt <= tickCnt + 1'b1;
                                        if (bitMiddle) begin
                                                rxStrobe <= 1'b1;         // 9.5 bits after start
                                                errPulse <= ~serialSync;  // Stop bit must be high
                                                state    <= stIdle;
                                        end
                                end
                                default: state <= stIdle;
                        endcase
                end
        end

        // Data bits arrive LSB first
        always_ff @(posedge Data_Rdy) begin
                if (state == stData && bitMiddle) begin
                        shiftReg <= {serialSync, shiftReg[`DATA_BITS-1:1]};
                end
        end

        assign rxByte = '{frameErr: errPulse, data: shiftReg};

endmodule

//--- logic/rxPathPkg.sv
`include "rxPath_params.svh"

package rxPathPkg;

        ////////////////////
        // Receiver output
        ////////////////////

        // Byte as it leaves the UART receiver
        typedef struct packed {
                logic                  frameErr;   // Stop bit was sampled low
                logic [`DATA_BITS-1:0] data;       // Payload, LSB received first
        } rxByteT;

        ////////////////////
        // Assembled words
        ////////////////////

        // Command layout of a 16-bit word, high byte first on the line
        typedef struct packed {
                logic [3:0] opcode;    // Zero means plain data
                logic [3:0] channel;   // Target channel
                logic [7:0] payload;   // Low byte of the pair
        } cmdFieldsT;

        // Same word seen either as raw data or as command fields
        typedef union packed {
                logic [`WORD_BITS-1:0] raw;
                cmdFieldsT             cmd;
        } rxWordU;

        // Opcode that marks a data word
        localparam logic [3:0] OPC_DATA = 4'h0;

endpackage

//--- logic/rxPath_params.svh
`ifndef RXPATH_PARAMS_SVH
`define RXPATH_PARAMS_SVH

////////////////////
// Serial timing
////////////////////
`define CLKS_PER_BIT   16      // System clocks per serial bit

////////////////////
// Buffer and words
////////////////////
`define FIFO_ADDR_BITS 4       // 16 FIFO entries
`define DATA_BITS      8       // One received byte
`define WORD_BITS      16      // Two bytes per assembled word

`endif
